//--- Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
BUILD_DIR ?= build
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status follows the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(BUILD_DIR)

//--- logic/bus_port.sv
`timescale 1ns/1ps

module bus_port import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp,
    output axi_req_t axi,
    input  axi_rsp_t axi_in
);

    logic   busy;        // one transaction in flight
    logic   is_write;
    logic   aw_pend;     // aw not yet accepted
    logic   w_pend;      // w not yet accepted
    logic   ar_pend;
    addr_t  addr_q;
    xword_t wdata_q;
    logic   accept;
    logic   done;

    assign accept = bus_req.valid && !busy;
    // bready/rready tied high so the response handshake is just the valid
    assign done = busy && (is_write ? axi_in.bvalid : axi_in.rvalid);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy     <= 1'b0;
            is_write <= 1'b0;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
            ar_pend  <= 1'b0;
        end else if (accept) begin
            busy     <= 1'b1;
            is_write <= bus_req.write;
            aw_pend  <= bus_req.write;    // aw and w rise together
            w_pend   <= bus_req.write;
            ar_pend  <= !bus_req.write;
        end else begin
            if (done) busy <= 1'b0;
            if (aw_pend && axi_in.awready) aw_pend <= 1'b0;
            if (w_pend && axi_in.wready) w_pend <= 1'b0;
            if (ar_pend && axi_in.arready) ar_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= bus_req.addr;
            wdata_q <= bus_req.wdata;
        end
    end

    always_comb begin
        axi.awaddr  = addr_q;
        axi.awvalid = aw_pend;
        axi.wdata   = wdata_q;
        axi.wstrb   = 8'hff;      // full dword writes only
        axi.wvalid  = w_pend;
        axi.bready  = 1'b1;
        axi.araddr  = addr_q;
        axi.arvalid = ar_pend;
        axi.rready  = 1'b1;
    end

    assign bus_rsp.done  = done;
    assign bus_rsp.rdata = axi_in.rdata;   // bresp/rresp not checked

    a_aw_stable: assert property (@(posedge clk) disable iff (!reset)
        axi.awvalid && !axi_in.awready |=> axi.awvalid && $stable(axi.awaddr));

    // requester must hold its request until done, no second one sneaks in
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!reset)
        busy && !done |=> bus_req.valid && $stable(bus_req.addr) && !accept);

endmodule

//--- logic/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  op_kind_e   op_kind,
    input  bus_req_t   exec_req,          // ld/sd access from exec_unit
    input  logic [3:0] interrupt_vector,
    output bus_req_t   bus_req,
    input  bus_rsp_t   bus_rsp,
    output logic       advance,
    output logic       interrupt_done
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        irq_latched;   // service taken and waiting for the vector to change
    logic        key_hit;
    logic        irq_take;
    logic        mem_op;
    xword_t      key_value;     // key byte on its way to the uart

    assign key_hit  = (interrupt_vector == key_irq_vector);
    assign irq_take = (state == run) && key_hit && !irq_latched;
    assign mem_op   = (op_kind == ld) || (op_kind == sd);

    always_comb begin
        next_state = state;
        advance    = 1'b0;
        bus_req    = '0;
        case (state)
            run: begin
                if (irq_take) begin
                    next_state = irq_read;    // ir instruction waits
                end else if (mem_op) begin
                    next_state = mem_wait;
                end else begin
                    advance = 1'b1;           // retire alu op or nop
                end
            end
            mem_wait: begin
                bus_req = exec_req;
                if (bus_rsp.done) begin
                    advance    = 1'b1;        // ld writes rd this cycle
                    next_state = run;
                end
            end
            irq_read: begin
                bus_req.valid = 1'b1;
                bus_req.addr  = key_base;
                if (bus_rsp.done) next_state = irq_write;
            end
            irq_write: begin
                bus_req.valid = 1'b1;
                bus_req.write = 1'b1;
                bus_req.addr  = uart_base;
                bus_req.wdata = key_value;
                if (bus_rsp.done) next_state = irq_done;
            end
            irq_done: next_state = run;
            default:  next_state = run;
        endcase
    end

    assign interrupt_done = (state == irq_done);   // pulse on the way back to run

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= run;
            irq_latched <= 1'b0;
        end else begin
            state <= next_state;
            if (irq_take) begin
                irq_latched <= 1'b1;
            end else if (!key_hit) begin
                irq_latched <= 1'b0;   // vector left so rearm
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == irq_read && bus_rsp.done) key_value <= bus_rsp.rdata;
    end

    // memory traffic only ever leaves the core from a stall state
    // and no response may arrive while nothing is outstanding
    a_no_req_in_run: assert property (@(posedge clk) disable iff (!reset)
        (state == run) |-> !bus_req.valid && !bus_rsp.done);

    // one pulse per completed uart write
    a_done_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done |-> $past(bus_rsp.done) && !bus_rsp.done);

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import rv_pkg::*; (
    input  inst_t    ir,
    input  xword_t   rs1_data,
    input  xword_t   rs2_data,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output op_kind_e op_kind,
    output xword_t   wr_data,
    output logic     wr_en,
    output bus_req_t exec_req,
    input  xword_t   rdata        // load data, valid with done
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xword_t     imm_i;
    xword_t     imm_s;
    xword_t     imm_u;
    exec_op_t   dec;
    xword_t     operand_b;
    xword_t     sum;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};   // rv64 lui sign extends

    always_comb begin
        dec.kind = nop;
        dec.rd   = ir[11:7];
        dec.rs1  = ir[19:15];
        dec.rs2  = ir[24:20];
        dec.imm  = imm_i;
        case (opcode)
            opc_lui: begin
                dec.kind = lui;
                dec.imm  = imm_u;
            end
            opc_op_imm: if (funct3 == 3'b000) dec.kind = addi;
            opc_op:     if (funct3 == 3'b000 && funct7 == 7'b0) dec.kind = add;
            opc_load:   if (funct3 == 3'b011) dec.kind = ld;     // dword only
            opc_store: begin
                if (funct3 == 3'b011) dec.kind = sd;
                dec.imm = imm_s;
            end
            default: dec.kind = nop;   // anything else retires silently
        endcase
    end

    assign rs1     = dec.rs1;
    assign rs2     = dec.rs2;
    assign rd      = dec.rd;
    assign op_kind = dec.kind;

    // one adder serves addi, add and address generation
    assign operand_b = (dec.kind == add) ? rs2_data : dec.imm;
    assign sum       = rs1_data + operand_b;

    always_comb begin
        case (dec.kind)
            lui:     wr_data = dec.imm;
            ld:      wr_data = rdata;
            default: wr_data = sum;
        endcase
    end

    assign wr_en = (dec.kind == lui) || (dec.kind == addi) ||
                   (dec.kind == add) || (dec.kind == ld);

    assign exec_req.valid = (dec.kind == ld) || (dec.kind == sd);
    assign exec_req.write = (dec.kind == sd);
    assign exec_req.addr  = sum[31:0];   // bus is 32 bit addressed
    assign exec_req.wdata = rs2_data;

endmodule

//--- logic/pc_counter.sv
`timescale 1ns/1ps

module pc_counter import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  advance,    // one instruction retired
    output addr_t pc
);

    // fetch pointer, holds while the core stalls
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= pc + 32'd4;    // next word
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  xword_t   wr_data,
    input  logic     wr_en,      // already qualified by advance
    output xword_t   rs1_data,
    output xword_t   rs2_data
);

    xword_t regs [32];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;   // known state for the model compare
            end
        end else if (wr_en && rd != 5'd0) begin
            regs[rd] <= wr_data;
        end
    end

    // x0 hardwired
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- logic/riscv_core.sv
`timescale 1ns/1ps

module riscv_core import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  inst_t      instruction,        // must match pc in the same cycle
    output addr_t      pc,
    input  logic [3:0] interrupt_vector,
    output logic       interrupt_done,
    output axi_req_t   axi,
    input  axi_rsp_t   axi_in
);

    inst_t    ir;
    logic     advance;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xword_t   rs1_data;
    xword_t   rs2_data;
    xword_t   wr_data;
    logic     wr_en;
    op_kind_e op_kind;
    bus_req_t exec_req;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    // fetch stage, all zero word decodes as nop
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= '0;
        end else if (advance) begin
            ir <= instruction;
        end
    end

    pc_counter i_pc_counter (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .pc      (pc)
    );

    core_ctrl i_core_ctrl (
        .clk              (clk),
        .reset            (reset),
        .op_kind          (op_kind),
        .exec_req         (exec_req),
        .interrupt_vector (interrupt_vector),
        .bus_req          (bus_req),
        .bus_rsp          (bus_rsp),
        .advance          (advance),
        .interrupt_done   (interrupt_done)
    );

    exec_unit i_exec_unit (
        .ir       (ir),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .op_kind  (op_kind),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .exec_req (exec_req),
        .rdata    (bus_rsp.rdata)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wr_data  (wr_data),
        .wr_en    (wr_en && advance),   // write only when the op retires
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    bus_port i_bus_port (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .axi     (axi),
        .axi_in  (axi_in)
    );

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    typedef logic [63:0] xword_t;     // register / data word
    typedef logic [31:0] addr_t;      // bus and pc address
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    localparam addr_t      reset_pc       = 32'h0000_0000;
    localparam addr_t      key_base       = 32'h8000_0010;  // keyboard data reg
    localparam addr_t      uart_base      = 32'h8000_0000;  // uart tx reg
    localparam logic [3:0] key_irq_vector = 4'd1;

    // major opcodes, rv64i base
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    typedef enum logic [2:0] {nop, lui, addi, add, ld, sd} op_kind_e;

    typedef enum logic [2:0] {run, mem_wait, irq_read, irq_write, irq_done} ctrl_state_e;

    typedef struct packed {
        op_kind_e kind;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xword_t   imm;        // already sign extended
    } exec_op_t;

    typedef struct packed {
        logic   valid;
        logic   write;
        addr_t  addr;
        xword_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic   done;         // one cycle pulse
        xword_t rdata;
    } bus_rsp_t;

    // master side of axi4-lite
    typedef struct packed {
        addr_t      awaddr;
        logic       awvalid;
        xword_t     wdata;
        logic [7:0] wstrb;
        logic       wvalid;
        logic       bready;
        addr_t      araddr;
        logic       arvalid;
        logic       rready;
    } axi_req_t;

    // slave side of axi4-lite
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
        logic       arready;
        xword_t     rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axi_rsp_t;

endpackage

//--- sources.f
logic/rv_pkg.sv
logic/pc_counter.sv
logic/core_ctrl.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/bus_port.sv
logic/riscv_core.sv
testbench/tb_bus_memory.sv
testbench/tb_riscv_core.sv

//--- testbench/tb_bus_memory.sv
`timescale 1ns/1ps

module tb_bus_memory import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  axi_req_t axi_req,
    output axi_rsp_t axi_rsp,
    output logic     wr_seen,      // ordinary write committed this cycle
    output addr_t    wr_addr,
    output xword_t   wr_data,
    output logic     uart_seen,    // write to the uart register
    output xword_t   uart_data,
    output xword_t   key_sent      // key value handed out by the last key read
);

    integer seed = 32'h6de8;
    xword_t mem [addr_t];       // sparse data memory
    xword_t key;                // current keyboard register
    addr_t  aw_addr;
    xword_t w_data;
    addr_t  ar_addr;
    logic   aw_got;             // write address captured
    logic   w_got;              // write data captured
    logic   ar_got;

    function automatic xword_t read_word(addr_t a);
        if (a == key_base) return key;
        if (mem.exists(a)) return mem[a];
        return {~a, a};         // untouched words depend on the full address
    endfunction

    always @(posedge clk or negedge reset) begin
        logic [31:0] r;
        if (!reset) begin
            axi_rsp   <= '0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_got    <= 1'b0;
            wr_seen   <= 1'b0;
            uart_seen <= 1'b0;
            key       <= {56'h0, 8'h3c};
            key_sent  <= '0;
        end else begin
            r = $random(seed);      // one draw per cycle, bits spread over the channels
            wr_seen   <= 1'b0;
            uart_seen <= 1'b0;

            // aw and w accepted independently
            if (axi_req.awvalid && axi_rsp.awready) begin
                aw_addr <= axi_req.awaddr;
                aw_got  <= 1'b1;
            end
            if (axi_req.wvalid && axi_rsp.wready) begin
                w_data <= axi_req.wdata;
                w_got  <= 1'b1;
            end
            axi_rsp.awready <= r[0] && !aw_got && !(axi_req.awvalid && axi_rsp.awready);
            axi_rsp.wready  <= r[1] && !w_got && !(axi_req.wvalid && axi_rsp.wready);

            // response once both halves are in
            if (aw_got && w_got && !axi_rsp.bvalid && r[2]) begin
                axi_rsp.bvalid <= 1'b1;
                axi_rsp.bresp  <= 2'b00;
                if (aw_addr == uart_base) begin
                    uart_seen <= 1'b1;      // uart writes never reach the memory
                    uart_data <= w_data;
                end else begin
                    mem[aw_addr] = w_data;
                    wr_seen <= 1'b1;
                    wr_addr <= aw_addr;
                    wr_data <= w_data;
                end
            end
            if (axi_rsp.bvalid && axi_req.bready) begin
                axi_rsp.bvalid <= 1'b0;
                aw_got         <= 1'b0;
                w_got          <= 1'b0;
            end

            // read channel
            if (axi_req.arvalid && axi_rsp.arready) begin
                ar_addr <= axi_req.araddr;
                ar_got  <= 1'b1;
            end
            axi_rsp.arready <= r[3] && !ar_got && !(axi_req.arvalid && axi_rsp.arready);
            if (ar_got && !axi_rsp.rvalid && r[4]) begin
                axi_rsp.rvalid <= 1'b1;
                axi_rsp.rresp  <= 2'b00;
                axi_rsp.rdata  <= read_word(ar_addr);
                if (ar_addr == key_base) begin
                    key_sent <= key;
                    key      <= {56'h0, r[15:8]};   // next keypress
                end
            end
            if (axi_rsp.rvalid && axi_req.rready) begin
                axi_rsp.rvalid <= 1'b0;
                ar_got         <= 1'b0;
            end
        end
    end

endmodule

//--- testbench/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core import rv_pkg::*; ();

    logic       clk;
    logic       reset;
    inst_t      instruction;
    addr_t      pc;
    logic [3:0] interrupt_vector;
    logic       interrupt_done;
    axi_req_t   axi;
    axi_rsp_t   axi_in;

    logic       wr_seen;
    addr_t      wr_addr;
    xword_t     wr_data;
    logic       uart_seen;
    xword_t     uart_data;
    xword_t     key_sent;

    inst_t      prog [$];          // word i sits at pc 4*i
    addr_t      exp_addr [$];      // store order from the model
    xword_t     exp_data [$];
    int         store_idx   = 0;
    int         uart_count  = 0;
    int         done_pulses = 0;
    logic       done_prev   = 1'b0;

    initial clk = 1'b0;
    always #10 clk = ~clk;          // 20 ns period

    riscv_core i_riscv_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .interrupt_vector (interrupt_vector),
        .interrupt_done   (interrupt_done),
        .axi              (axi),
        .axi_in           (axi_in)
    );

    tb_bus_memory i_bus_memory (
        .clk       (clk),
        .reset     (reset),
        .axi_req   (axi),
        .axi_rsp   (axi_in),
        .wr_seen   (wr_seen),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .uart_seen (uart_seen),
        .uart_data (uart_data),
        .key_sent  (key_sent)
    );

    function automatic inst_t lui_word(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, opc_lui};
    endfunction

    // addi, ld and friends
    function automatic inst_t itype_word(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                         reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t add_word(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, opc_op};
    endfunction

    function automatic inst_t sd_word(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], opc_store};
    endfunction

    task automatic load_program();
        prog.delete();
        prog.push_back(lui_word(5'd1, 20'h12345));
        prog.push_back(itype_word(opc_op_imm, 3'b000, 5'd1, 5'd1, 12'h678));
        prog.push_back(lui_word(5'd2, 20'hfffff));                           // negative upper
        prog.push_back(itype_word(opc_op_imm, 3'b000, 5'd3, 5'd2, 12'hfff));
        prog.push_back(add_word(5'd4, 5'd1, 5'd3));
        prog.push_back(add_word(5'd4, 5'd4, 5'd4));
        prog.push_back(itype_word(opc_op_imm, 3'b000, 5'd6, 5'd0, 12'h800));
        prog.push_back(lui_word(5'd5, 20'h00001));                           // data base 0x1000
        prog.push_back(sd_word(5'd1, 5'd5, 12'h000));
        prog.push_back(sd_word(5'd3, 5'd5, 12'h008));
        prog.push_back(sd_word(5'd4, 5'd5, 12'h010));
        prog.push_back(sd_word(5'd6, 5'd5, 12'h018));
        prog.push_back(itype_word(opc_load, 3'b011, 5'd7, 5'd5, 12'h008));
        prog.push_back(itype_word(opc_op_imm, 3'b000, 5'd0, 5'd7, 12'h005)); // x0 target
        prog.push_back(sd_word(5'd7, 5'd5, 12'h020));                        // loaded value
        prog.push_back(sd_word(5'd0, 5'd5, 12'h028));
        prog.push_back(itype_word(opc_load, 3'b011, 5'd8, 5'd5, 12'h010));
        prog.push_back(add_word(5'd9, 5'd8, 5'd7));                          // load to use
        prog.push_back(sd_word(5'd9, 5'd5, 12'hff8));                        // below base
        prog.push_back(itype_word(opc_load, 3'b010, 5'd10, 5'd5, 12'h000));  // lw is not run
        prog.push_back(32'h0000_0073);                                       // ecall
        prog.push_back(sd_word(5'd10, 5'd5, 12'h030));
        prog.push_back(sd_word(5'd8, 5'd5, 12'h038));
    endtask

    // straight line ISA model of the subset that fills the expected store list
    function automatic void golden_run();
        xword_t   regs [32];
        xword_t   dmem [addr_t];
        inst_t    w;
        reg_idx_t rd;
        xword_t   a;
        xword_t   b;
        xword_t   imm_i;
        xword_t   imm_s;
        xword_t   res;
        logic     wr;
        addr_t    ea;
        regs = '{default: '0};
        exp_addr.delete();
        exp_data.delete();
        foreach (prog[i]) begin
            w     = prog[i];
            rd    = w[11:7];
            a     = regs[w[19:15]];
            b     = regs[w[24:20]];
            imm_i = {{52{w[31]}}, w[31:20]};
            imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
            wr    = 1'b0;
            res   = '0;
            case (w[6:0])
                opc_lui: begin
                    res = {{32{w[31]}}, w[31:12], 12'h000};
                    wr  = 1'b1;
                end
                opc_op_imm: begin
                    res = a + imm_i;
                    wr  = (w[14:12] == 3'b000);
                end
                opc_op: begin
                    res = a + b;
                    wr  = (w[14:12] == 3'b000) && (w[31:25] == 7'b0);
                end
                opc_load: if (w[14:12] == 3'b011) begin
                    ea  = addr_t'(a + imm_i);
                    res = dmem.exists(ea) ? dmem[ea] : {~ea, ea};
                    wr  = 1'b1;
                end
                opc_store: if (w[14:12] == 3'b011) begin
                    ea       = addr_t'(a + imm_s);
                    dmem[ea] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                default: wr = 1'b0;    // retires as nop
            endcase
            if (wr && rd != 5'd0) regs[rd] = res;
        end
    endfunction

    function automatic inst_t fetch_word(addr_t a);
        int idx;
        idx = int'(a >> 2);
        if (idx < prog.size()) return prog[idx];
        return '0;                 // past the end runs nops
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic fail_with(string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_value(string name, xword_t got, xword_t exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_for_stores(int n, int limit);
        int cycles;
        cycles = 0;
        while (store_idx < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_with($sformatf("timeout: only %0d of %0d stores arrived", store_idx, n));
            end
        end
    endtask

    task automatic wait_for_uart(int n, int limit);
        int cycles;
        cycles = 0;
        while (uart_count < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_with($sformatf("timeout: uart write %0d never arrived", n));
            end
        end
    endtask

    // instruction follows pc just after the edge
    always @(posedge clk) begin
        #1;
        instruction = fetch_word(pc);
    end

    // compare process samples everything mid cycle
    always @(negedge clk) begin
        if (reset && axi.wvalid) begin
            check_value("wstrb", {56'h0, axi.wstrb}, 64'hff);   // full dword writes
        end
        if (reset && wr_seen) begin
            if (store_idx >= exp_addr.size()) begin
                fail_with($sformatf("extra store to %h beyond the program", wr_addr));
            end else begin
                check_value("awaddr", {32'h0, wr_addr}, {32'h0, exp_addr[store_idx]});
                check_value("wdata", wr_data, exp_data[store_idx]);
                store_idx++;
            end
        end
        if (reset && uart_seen) begin
            check_value("uart wdata", uart_data, key_sent);   // key read earlier
            uart_count++;
        end
        if (reset && interrupt_done) begin
            if (done_prev) fail_with("interrupt_done stayed high for a second cycle");
            done_pulses++;
        end
        done_prev = interrupt_done;
    end

    initial begin
        reset            = 1'b0;
        instruction      = '0;
        interrupt_vector = 4'd0;
        load_program();
        golden_run();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;

        // state straight out of reset
        check_value("pc", {32'h0, pc}, {32'h0, reset_pc});
        check_value("awvalid", {63'h0, axi.awvalid}, 64'h0);
        check_value("wvalid", {63'h0, axi.wvalid}, 64'h0);
        check_value("arvalid", {63'h0, axi.arvalid}, 64'h0);
        check_value("interrupt_done", {63'h0, interrupt_done}, 64'h0);
        check_value("bready", {63'h0, axi.bready}, 64'h1);
        check_value("rready", {63'h0, axi.rready}, 64'h1);

        // one retire per cycle through the alu only stretch
        for (int k = 0; k <= 8; k++) begin
            @(negedge clk);
            check_value("pc", {32'h0, pc}, 64'(4 * k));
        end

        // first key service lands mid program
        wait_for_stores(2, 400);
        @(posedge clk);
        #1;
        interrupt_vector = key_irq_vector;
        wait_for_uart(1, 200);

        // service must not repeat while the vector is held
        repeat (30) @(negedge clk);
        check_value("uart writes", 64'(uart_count), 64'd1);
        check_value("interrupt_done pulses", 64'(done_pulses), 64'd1);

        // another source in between rearms the key service
        @(posedge clk);
        #1;
        interrupt_vector = 4'd2;
        repeat (3) @(posedge clk);
        #1;
        interrupt_vector = key_irq_vector;
        wait_for_uart(2, 200);
        @(posedge clk);
        #1;
        interrupt_vector = 4'd0;

        wait_for_stores(exp_addr.size(), 2000);
        repeat (20) @(negedge clk);    // room for stray traffic
        check_value("interrupt_done pulses", 64'(done_pulses), 64'd2);

        if (store_idx == exp_addr.size() && uart_count == 2) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_with("store or uart count wrong at the end of the run");
        end
    end

endmodule
